// File: verilog/uart_pkg.sv
// uart package: bit timing, frame and buffer sizes, receive FSM state codes, counter command
`default_nettype none

package uart_pkg;

    localparam int CLKS_PER_BIT = 8;   // short bit time keeps simulation quick
    localparam int FIRST_SAMPLE = 12;  // start edge to middle of data bit 0
    localparam int DATA_BITS    = 8;
    localparam int FIFO_DEPTH   = 4;   // power of two, pointers wrap on their own

    // one width serves the baud and bit counters of both directions
    localparam int CNT_W      = $clog2(FIRST_SAMPLE);
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // receive FSM states
    localparam logic [2:0] ST_IDLE       = 3'd0;  // line idle, waiting for start edge
    localparam logic [2:0] ST_WAIT_FIRST = 3'd1;  // count to middle of data bit 0
    localparam logic [2:0] ST_SHIFT      = 3'd2;  // take one data bit
    localparam logic [2:0] ST_CHECK      = 3'd3;  // all data bits in yet?
    localparam logic [2:0] ST_WAIT_NEXT  = 3'd4;  // count to middle of next data bit
    localparam logic [2:0] ST_WAIT_STOP  = 3'd5;  // count to middle of stop bit
    localparam logic [2:0] ST_STOP_CHECK = 3'd6;  // judge stop bit

    // command for a datapath counter
    typedef enum logic [1:0] {
        CNT_ZERO  = 2'b00,
        CNT_HOLD  = 2'b01,
        CNT_COUNT = 2'b11
    } cnt_sel_t;

endpackage

`default_nettype wire

// File: verilog/uart_rx_controller.sv
// uart receive control FSM: start edge detection, data and stop sampling sequence
`timescale 1ns/1ps
`default_nettype none

module uart_rx_controller (
    input  logic               clk,
    input  logic               reset_b,
    input  logic               rx_sync,
    input  logic               baud_hit,
    input  logic               bits_done,
    output uart_pkg::cnt_sel_t baud_sel,
    output uart_pkg::cnt_sel_t bit_sel,
    output logic               mid_sel,
    output logic               shift_en,
    output logic               push,
    output logic               frame_error
);
    import uart_pkg::*;

    logic [2:0] state;
    logic [2:0] next_state;
    logic       rx_prev;     // line one cycle back
    logic       start_edge;

    // only a falling edge starts a frame, so a low stop bit
    // cannot retrigger the receiver while the line is still low
    assign start_edge = rx_prev & ~rx_sync;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state   <= ST_IDLE;
            rx_prev <= 1'b1;     // idle line level
        end else begin
            state   <= next_state;
            rx_prev <= rx_sync;
        end
    end

    always_comb begin
        shift_en    = 1'b0;
        push        = 1'b0;
        frame_error = 1'b0;
        case (state)
            ST_IDLE: begin
                baud_sel   = CNT_ZERO;
                bit_sel    = CNT_ZERO;
                mid_sel    = 1'b1;          // 1.5 bit compare for bit 0
                next_state = start_edge ? ST_WAIT_FIRST : ST_IDLE;
            end

            ST_WAIT_FIRST: begin
                baud_sel   = CNT_COUNT;
                bit_sel    = CNT_ZERO;
                mid_sel    = 1'b1;
                next_state = baud_hit ? ST_SHIFT : ST_WAIT_FIRST;
            end

            ST_SHIFT: begin
                baud_sel   = CNT_ZERO;      // restart bit timing here
                bit_sel    = CNT_COUNT;
                mid_sel    = 1'b0;
                shift_en   = 1'b1;
                next_state = ST_CHECK;
            end

            ST_CHECK: begin
                baud_sel   = CNT_COUNT;
                bit_sel    = CNT_HOLD;
                mid_sel    = 1'b0;
                next_state = bits_done ? ST_WAIT_STOP : ST_WAIT_NEXT;
            end

            ST_WAIT_NEXT: begin
                baud_sel   = CNT_COUNT;
                bit_sel    = CNT_HOLD;
                mid_sel    = 1'b0;          // full bit compare
                next_state = baud_hit ? ST_SHIFT : ST_WAIT_NEXT;
            end

            ST_WAIT_STOP: begin
                baud_sel   = CNT_COUNT;
                bit_sel    = CNT_HOLD;
                mid_sel    = 1'b0;
                next_state = baud_hit ? ST_STOP_CHECK : ST_WAIT_STOP;
            end

            ST_STOP_CHECK: begin
                baud_sel    = CNT_ZERO;
                bit_sel     = CNT_ZERO;
                mid_sel     = 1'b1;
                push        = rx_sync;      // good stop bit, byte goes to FIFO
                frame_error = ~rx_sync;     // byte dropped
                next_state  = ST_IDLE;
            end

            default: begin
                baud_sel   = CNT_ZERO;
                bit_sel    = CNT_ZERO;
                mid_sel    = 1'b1;
                next_state = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uart_rx_datapath.sv
// uart receive datapath: rxd synchronizer, baud and bit counters, receive shift register
`timescale 1ns/1ps
`default_nettype none

module uart_rx_datapath (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic                           rxd,
    input  uart_pkg::cnt_sel_t             baud_sel,
    input  uart_pkg::cnt_sel_t             bit_sel,
    input  logic                           mid_sel,
    input  logic                           shift_en,
    output logic                           rx_sync,
    output logic                           baud_hit,
    output logic                           bits_done,
    output logic [uart_pkg::DATA_BITS-1:0] rx_byte
);
    import uart_pkg::*;

    logic             rx_meta;   // first synchronizer stage
    logic [CNT_W-1:0] baud_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] baud_cmp;

    function automatic logic [CNT_W-1:0] cnt_next(input cnt_sel_t         sel,
                                                  input logic [CNT_W-1:0] cur);
        case (sel)
            CNT_ZERO:  cnt_next = '0;
            CNT_COUNT: cnt_next = cur + 1'b1;
            default:   cnt_next = cur;
        endcase
    endfunction

    // two FSM cycles sit outside the counting window
    // (the zeroing state and the state that acts on the hit)
    assign baud_cmp  = mid_sel ? CNT_W'(FIRST_SAMPLE - 2) : CNT_W'(CLKS_PER_BIT - 2);
    assign baud_hit  = (baud_cnt == baud_cmp);
    assign bits_done = (bit_cnt == CNT_W'(DATA_BITS));

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_meta <= 1'b1;     // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= cnt_next(baud_sel, baud_cnt);
            bit_cnt  <= cnt_next(bit_sel, bit_cnt);
        end
    end

    // new bit enters at the top, first bit ends up in bit 0
    always_ff @(posedge clk) begin
        if (shift_en) begin
            rx_byte <= {rx_sync, rx_byte[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_rx_fifo.sv
// uart receive FIFO: circular byte buffer with valid/ready output and overrun flag
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic                           push,
    input  logic [uart_pkg::DATA_BITS-1:0] rx_byte,
    input  logic                           rx_ready,
    output logic [uart_pkg::DATA_BITS-1:0] rx_data,
    output logic                           rx_valid,
    output logic                           overrun
);
    import uart_pkg::*;

    logic [DATA_BITS-1:0]  mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [FIFO_CNT_W-1:0] count;    // occupancy
    logic                  full;
    logic                  pop;
    logic                  wr_en;

    assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign rx_valid = (count != '0);
    assign rx_data  = mem[rd_ptr];     // oldest byte
    assign pop      = rx_valid & rx_ready;
    assign wr_en    = push & (~full | pop);  // same cycle pop frees a slot

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= rx_byte;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            overrun <= push & ~wr_en;      // incoming byte lost
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// uart transmitter: valid/ready byte input, start/data/stop serializer with bit timing
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    input  logic                           tx_valid,
    output logic                           tx_ready,
    output logic                           txd
);
    import uart_pkg::*;

    logic [DATA_BITS+1:0] frame;     // stop, data, start; goes out from bit 0
    logic [CNT_W-1:0]     baud_cnt;
    logic [CNT_W-1:0]     bit_cnt;   // index of the bit on the line
    logic                 busy;
    logic                 start;
    logic                 bit_end;
    logic                 last_bit;

    assign start    = tx_valid & tx_ready;
    assign bit_end  = (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign last_bit = (bit_cnt == CNT_W'(DATA_BITS + 1));   // stop bit
    assign tx_ready = ~busy;
    assign txd      = frame[0];

    // busy from the transfer until the stop bit has run its full time
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (busy && bit_end && last_bit) begin
            busy <= 1'b0;
        end
    end

    // the frame register drives the line, so it resets to idle high
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            frame <= '1;
        end else if (start) begin
            frame <= {1'b1, tx_data, 1'b0};
        end else if (busy && bit_end) begin
            frame <= {1'b1, frame[DATA_BITS+1:1]};   // refill with idle level
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (start) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy) begin
            if (bit_end) begin
                baud_cnt <= '0;
                bit_cnt  <= bit_cnt + 1'b1;
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
// uart top level: receive datapath and FSM, receive FIFO, transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic                           rxd,
    output logic                           txd,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    input  logic                           tx_valid,
    output logic                           tx_ready,
    output logic [uart_pkg::DATA_BITS-1:0] rx_data,
    output logic                           rx_valid,
    input  logic                           rx_ready,
    output logic                           frame_error,
    output logic                           overrun
);
    import uart_pkg::*;

    logic                 rx_sync;
    logic                 baud_hit;
    logic                 bits_done;
    cnt_sel_t             baud_sel;
    cnt_sel_t             bit_sel;
    logic                 mid_sel;
    logic                 shift_en;
    logic                 push;      // good frame into FIFO
    logic [DATA_BITS-1:0] rx_byte;

    uart_rx_datapath uart_rx_datapath_inst (
        .clk       (clk),
        .reset_b   (reset_b),
        .rxd       (rxd),
        .baud_sel  (baud_sel),
        .bit_sel   (bit_sel),
        .mid_sel   (mid_sel),
        .shift_en  (shift_en),
        .rx_sync   (rx_sync),
        .baud_hit  (baud_hit),
        .bits_done (bits_done),
        .rx_byte   (rx_byte)
    );

    uart_rx_controller uart_rx_controller_inst (
        .clk         (clk),
        .reset_b     (reset_b),
        .rx_sync     (rx_sync),
        .baud_hit    (baud_hit),
        .bits_done   (bits_done),
        .baud_sel    (baud_sel),
        .bit_sel     (bit_sel),
        .mid_sel     (mid_sel),
        .shift_en    (shift_en),
        .push        (push),
        .frame_error (frame_error)
    );

    uart_rx_fifo uart_rx_fifo_inst (
        .clk      (clk),
        .reset_b  (reset_b),
        .push     (push),
        .rx_byte  (rx_byte),
        .rx_ready (rx_ready),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .overrun  (overrun)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .reset_b  (reset_b),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

endmodule

`default_nettype wire

// File: verification/tb_uart_top.sv
// testbench for the uart top level: clock, reset, watchdog, serial driver and monitor, directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;
    import uart_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;       // start, data, stop
    localparam int N_TX         = 4;
    localparam int N_RX         = 3;
    localparam int N_LOOP       = 4;
    localparam int ALL_FRAMES   = N_TX + N_RX + 2 + (FIFO_DEPTH + 1) + N_LOOP;
    localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;        // longest wait for one handshake
    localparam int WATCHDOG     = 2 * ALL_FRAMES * FRAME_CYCLES + 200;

    logic                 clk;
    logic                 reset_b;
    logic                 rxd;
    logic                 rxd_drv;
    logic                 loopback;     // txd fed back to rxd
    logic                 txd;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_valid;
    logic                 tx_ready;
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_valid;
    logic                 rx_ready;
    logic                 frame_error;
    logic                 overrun;
    logic [31:0]          rng_state = 32'h83a;
    int                   frame_err_seen = 0;
    int                   overrun_seen = 0;

    assign rxd = loopback ? txd : rxd_drv;

    uart_top uart_top_inst (
        .clk         (clk),
        .reset_b     (reset_b),
        .rxd         (rxd),
        .txd         (txd),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .frame_error (frame_error),
        .overrun     (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // pulse monitor, sampled away from the rising edge
    always @(negedge clk) begin
        if (frame_error) frame_err_seen++;
        if (overrun) overrun_seen++;
    end

    function automatic logic [DATA_BITS-1:0] random_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[16 +: DATA_BITS];    // upper bits are the better ones
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "mismatch");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_byte(input string name, input logic [DATA_BITS-1:0] got,
                              input logic [DATA_BITS-1:0] exp);
        assert (got === exp) else report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic expect_pulses(input string name, input int got, input int exp);
        assert (got == exp) else report_mismatch(name, got, exp);
    endtask

    // inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // one 8N1 frame on rxd, line left idle high
    task automatic send_serial(input logic [DATA_BITS-1:0] b, input logic bad_stop);
        rxd_drv = 1'b0;
        wait_cycles(CLKS_PER_BIT);
        for (int i = 0; i < DATA_BITS; i++) begin
            rxd_drv = b[i];
            wait_cycles(CLKS_PER_BIT);
        end
        rxd_drv = ~bad_stop;
        wait_cycles(CLKS_PER_BIT);
        rxd_drv = 1'b1;
        if (bad_stop) wait_cycles(CLKS_PER_BIT);    // rising edge before the next start
    endtask

    // returns just after the transfer edge
    task automatic offer_tx_byte(input logic [DATA_BITS-1:0] b);
        int waited;
        waited   = 0;
        tx_data  = b;
        tx_valid = 1'b1;
        while (tx_ready !== 1'b1) begin
            if (waited == WAIT_LIMIT) abort_run("timeout: tx_ready never rose");
            next_cycle();
            waited++;
        end
        next_cycle();
        tx_valid = 1'b0;
    endtask

    // samples txd in the middle of each bit, starting right after a transfer
    task automatic capture_serial(output logic [DATA_BITS-1:0] got);
        wait_cycles(CLKS_PER_BIT / 2);
        check_bit("txd start bit", txd, 1'b0);
        check_bit("tx_ready", tx_ready, 1'b0);
        for (int i = 0; i < DATA_BITS; i++) begin
            wait_cycles(CLKS_PER_BIT);
            got[i] = txd;
            check_bit("tx_ready", tx_ready, 1'b0);
        end
        wait_cycles(CLKS_PER_BIT);
        check_bit("txd stop bit", txd, 1'b1);
        wait_cycles(CLKS_PER_BIT / 2 - 1);
        check_bit("tx_ready in last stop cycle", tx_ready, 1'b0);
        next_cycle();
        check_bit("tx_ready after frame", tx_ready, 1'b1);
    endtask

    task automatic expect_byte(input logic [DATA_BITS-1:0] exp);
        int waited;
        waited = 0;
        while (rx_valid !== 1'b1) begin
            if (waited == WAIT_LIMIT) abort_run("timeout: no byte arrived on rx_data");
            next_cycle();
            waited++;
        end
        check_byte("rx_data", rx_data, exp);
        rx_ready = 1'b1;    // pop on the next edge
        next_cycle();
        rx_ready = 1'b0;
    endtask

    task automatic check_reset_state();
        check_bit("txd", txd, 1'b1);
        check_bit("tx_ready", tx_ready, 1'b1);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("frame_error", frame_error, 1'b0);
        check_bit("overrun", overrun, 1'b0);
    endtask

    task automatic transmit_framing();
        logic [DATA_BITS-1:0] b;
        logic [DATA_BITS-1:0] got;
        repeat (N_TX) begin
            b = random_byte();
            offer_tx_byte(b);
            capture_serial(got);
            check_byte("txd data", got, b);
        end
    endtask

    task automatic receive_bytes();
        logic [DATA_BITS-1:0] sent[$];
        int                   fe_before;
        fe_before = frame_err_seen;
        repeat (N_RX) begin
            sent.push_back(random_byte());
            send_serial(sent[$], 1'b0);     // back to back, bytes wait in the FIFO
        end
        while (sent.size() > 0) expect_byte(sent.pop_front());
        expect_pulses("frame_error pulses", frame_err_seen - fe_before, 0);
    endtask

    task automatic frame_error_recovery();
        logic [DATA_BITS-1:0] b;
        int                   fe_before;
        fe_before = frame_err_seen;
        send_serial(random_byte(), 1'b1);
        expect_pulses("frame_error pulses", frame_err_seen - fe_before, 1);
        check_bit("rx_valid after bad frame", rx_valid, 1'b0);
        b = random_byte();
        send_serial(b, 1'b0);
        expect_byte(b);
        expect_pulses("frame_error pulses", frame_err_seen - fe_before, 1);
    endtask

    task automatic buffer_overrun();
        logic [DATA_BITS-1:0] sent[$];
        int                   ov_before;
        ov_before = overrun_seen;
        repeat (FIFO_DEPTH + 1) begin
            sent.push_back(random_byte());
            send_serial(sent[$], 1'b0);
        end
        wait_cycles(2);
        expect_pulses("overrun pulses", overrun_seen - ov_before, 1);
        repeat (FIFO_DEPTH) expect_byte(sent.pop_front());
        check_bit("rx_valid after drain", rx_valid, 1'b0);     // last byte was dropped
    endtask

    task automatic loopback_bytes();
        logic [DATA_BITS-1:0] b;
        loopback = 1'b1;
        repeat (N_LOOP) begin
            b = random_byte();
            offer_tx_byte(b);
            expect_byte(b);
        end
        loopback = 1'b0;
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        reset_b  = 1'b0;
        rxd_drv  = 1'b1;
        loopback = 1'b0;
        tx_data  = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        wait_cycles(8);
        reset_b = 1'b1;
        next_cycle();
        check_reset_state();
        transmit_framing();
        receive_bytes();
        frame_error_recovery();
        buffer_overrun();
        loopback_bytes();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/uart_pkg.sv
verilog/uart_rx_controller.sv
verilog/uart_rx_datapath.sv
verilog/uart_rx_fifo.sv
verilog/uart_tx.sv
verilog/uart_top.sv
verification/tb_uart_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the uart testbench with verilator and runs it; exit status is the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        -f filelist.f --top-module tb_uart_top -o sim_uart \
    && ./obj_dir/sim_uart \
    || exit 1
